// File: verilog/stream_pkg.sv
package stream_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 4;
    localparam int STRB_W     = 4;
    localparam int REG_NUM    = 4;
    localparam int FIFO_DEPTH = 8;  // Also the producer's credit count after reset.
    localparam int CREDIT_W   = 4;

    // Register indices. Index i sits at byte address 4*i.
    localparam int REG_CTRL  = 0;
    localparam int REG_START = 1;
    localparam int REG_STEP  = 2;
    localparam int REG_LEN   = 3;

    // ======================================================================
    // Types
    // ======================================================================
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [STRB_W-1:0]   strb_t;
    typedef logic [15:0]         count_t;
    typedef logic [7:0]          gap_t;
    typedef logic [CREDIT_W-1:0] credit_t;

endpackage

// File: verilog/axi4l_register.sv
`timescale 1ns/1ps

module axi4l_register (
    input  logic              s_axi4l,
    input  logic              rst_n,
    input  stream_pkg::addr_t awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  stream_pkg::data_t wdata,
    input  stream_pkg::strb_t wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  stream_pkg::addr_t araddr,
    input  logic              arvalid,
    output logic              arready,
    output stream_pkg::data_t rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    output stream_pkg::data_t regs [stream_pkg::REG_NUM]
);

    import stream_pkg::*;

    data_t                        reg_q [REG_NUM];
    logic [$clog2(REG_NUM)-1:0]   wr_idx;
    logic [$clog2(REG_NUM)-1:0]   rd_idx;
    logic                         wr_en;
    logic                         rd_en;

    // Replaces only the bytes whose strobe bit is set.
    function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                          input strb_t strb);
        data_t result;
        result = old_val;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign wr_idx = awaddr[2 +: $clog2(REG_NUM)];  // Word address from bits 3..2.
    assign rd_idx = araddr[2 +: $clog2(REG_NUM)];

    // ======================================================================
    // Write channel
    // ======================================================================
    assign awready = awvalid && wvalid && (!bvalid || bready);
    assign wready  = awready;                      // Address and data go together.
    assign wr_en   = awvalid && awready;
    assign bresp   = 2'b00;

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                reg_q[i] <= '0;
            end
            bvalid <= 1'b0;
        end else begin
            if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_en) begin
                reg_q[wr_idx] <= merge_bytes(reg_q[wr_idx], wdata, wstrb);
                bvalid        <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < REG_NUM; i++) begin
            regs[i] = reg_q[i];
        end
    end

    // ======================================================================
    // Read channel
    // ======================================================================
    assign arready = !rvalid || rready;
    assign rd_en   = arvalid && arready;
    assign rresp   = 2'b00;

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (rd_en) begin
            rdata <= reg_q[rd_idx];                // Held until the next accepted read.
        end
    end

endmodule

// File: verilog/pattern_producer.sv
`timescale 1ns/1ps

module pattern_producer (
    input  logic               s_axi4l,
    input  logic               rst_n,
    input  logic               enable,
    input  stream_pkg::data_t  start,
    input  stream_pkg::data_t  step,
    input  stream_pkg::count_t length,
    output logic               push,
    output stream_pkg::data_t  wdata_s,
    input  logic               credit
);

    import stream_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HOLD
    } state_t;

    state_t  state;
    credit_t credit_cnt;
    count_t  sent;
    data_t   word;

    // One word per cycle while the buffer has room for it.
    assign push    = (state == ST_RUN) && enable && (credit_cnt != '0);
    assign wdata_s = word;

    // ======================================================================
    // Sequencer
    // ======================================================================
    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            sent  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    sent <= '0;
                    if (enable) begin
                        state <= (length == '0) ? ST_HOLD : ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (!enable) begin
                        state <= ST_IDLE;                  // Run aborted by software.
                    end else if (push) begin
                        sent <= sent + 16'd1;
                        if (sent == length - 16'd1) begin
                            state <= ST_HOLD;
                        end
                    end
                end
                default: begin
                    if (!enable) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (state == ST_IDLE) begin
            word <= start;
        end else if (push) begin
            word <= word + step;                           // Stalls here when credits run out.
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            credit_cnt <= credit_t'(FIFO_DEPTH);
        end else begin
            credit_cnt <= credit_cnt + credit_t'(credit) - credit_t'(push);
        end
    end

    // A credit pulse without a matching pop would push the count past the depth.
    a_credit_bound: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        credit_cnt <= credit_t'(FIFO_DEPTH))
        else $error("credit count above buffer depth");

endmodule

// File: verilog/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo (
    input  logic              s_axi4l,
    input  logic              rst_n,
    input  logic              push,
    input  stream_pkg::data_t wdata_s,
    output logic              avail,
    output stream_pkg::data_t head,
    input  logic              pop,
    output logic              credit
);

    import stream_pkg::*;

    data_t                          mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr;
    credit_t                        count;

    // ======================================================================
    // Storage
    // ======================================================================
    always_ff @(posedge s_axi4l) begin
        if (push) begin
            mem[wr_ptr] <= wdata_s;
        end
    end

    assign head  = mem[rd_ptr];
    assign avail = (count != '0);

    // ======================================================================
    // Pointers and occupancy
    // ======================================================================
    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;                   // Wraps at the power-of-two depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + credit_t'(push) - credit_t'(pop);
        end
    end

    // Every freed slot goes back to the producer as one credit.
    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            credit <= 1'b0;
        end else begin
            credit <= pop;
        end
    end

    // The producer's credit count must keep it from ever filling past depth.
    a_no_overflow: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        push |-> count != credit_t'(FIFO_DEPTH))
        else $error("push into a full buffer");

    // The consumer is only allowed to take a word that is on offer.
    a_no_underflow: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        pop |-> count != '0)
        else $error("pop from an empty buffer");

endmodule

// File: verilog/checksum_consumer.sv
`timescale 1ns/1ps

module checksum_consumer (
    input  logic               s_axi4l,
    input  logic               rst_n,
    input  logic               enable,
    input  stream_pkg::count_t length,
    input  stream_pkg::gap_t   gap,
    input  logic               avail,
    input  stream_pkg::data_t  head,
    output logic               pop,
    output stream_pkg::data_t  sum,
    output stream_pkg::count_t received,
    output logic               done
);

    import stream_pkg::*;

    gap_t gap_cnt;

    // While disabled every word is drained so the buffer ends up empty.
    assign pop = enable ? (avail && gap_cnt == '0 && received != length) : avail;

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            sum      <= '0;
            received <= '0;
            done     <= 1'b0;
            gap_cnt  <= '0;
        end else if (!enable) begin
            sum      <= '0;
            received <= '0;
            done     <= 1'b0;
            gap_cnt  <= '0;
        end else begin
            if (pop) begin
                sum      <= sum + head;                    // Wraps modulo 2^32.
                received <= received + 16'd1;
                gap_cnt  <= gap;
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 8'd1;
            end
            if (received == length) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/stream_top.sv
`timescale 1ns/1ps

module stream_top (
    input  logic               s_axi4l,
    input  logic               rst_n,
    input  stream_pkg::addr_t  awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  stream_pkg::data_t  wdata,
    input  stream_pkg::strb_t  wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  stream_pkg::addr_t  araddr,
    input  logic               arvalid,
    output logic               arready,
    output stream_pkg::data_t  rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    output stream_pkg::data_t  sum,
    output stream_pkg::count_t received,
    output logic               done
);

    import stream_pkg::*;

    data_t  regs [REG_NUM];
    logic   enable;
    count_t length;
    gap_t   gap;
    logic   push;
    data_t  wdata_s;
    logic   credit;
    logic   avail;
    data_t  head;
    logic   pop;

    // ======================================================================
    // Register fields
    // ======================================================================
    assign enable = regs[REG_CTRL][0];
    assign length = regs[REG_LEN][15:0];
    assign gap    = regs[REG_LEN][23:16];      // Idle cycles after each pop.

    axi4l_register axi4l_register_inst (.*);

    pattern_producer pattern_producer_inst (
        .s_axi4l (s_axi4l),
        .rst_n   (rst_n),
        .enable  (enable),
        .start   (regs[REG_START]),
        .step    (regs[REG_STEP]),
        .length  (length),
        .push    (push),
        .wdata_s (wdata_s),
        .credit  (credit)
    );

    credit_fifo credit_fifo_inst (
        .s_axi4l (s_axi4l),
        .rst_n   (rst_n),
        .push    (push),
        .wdata_s (wdata_s),
        .avail   (avail),
        .head    (head),
        .pop     (pop),
        .credit  (credit)
    );

    checksum_consumer checksum_consumer_inst (
        .s_axi4l  (s_axi4l),
        .rst_n    (rst_n),
        .enable   (enable),
        .length   (length),
        .gap      (gap),
        .avail    (avail),
        .head     (head),
        .pop      (pop),
        .sum      (sum),
        .received (received),
        .done     (done)
    );

endmodule

// File: sim/stream_tb.sv
`timescale 1ns/1ps

module stream_tb;

    import stream_pkg::*;

    localparam int          NUM_RUNS        = 6;
    localparam int          MAX_COUNT       = 40;
    localparam int          MAX_GAP         = 5;
    localparam int          WATCHDOG_CYCLES = NUM_RUNS * (MAX_COUNT * (MAX_GAP + 2) + 100);
    localparam logic [31:0] SEED            = 32'h7127_43a8;
    localparam strb_t       STRB_LIST [8]   = '{4'hf, 4'h1, 4'h2, 4'h4,
                                                4'h8, 4'h6, 4'h9, 4'h3};

    logic        s_axi4l;
    logic        rst_n;
    addr_t       awaddr;
    logic        awvalid;
    logic        awready;
    data_t       wdata;
    strb_t       wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    addr_t       araddr;
    logic        arvalid;
    logic        arready;
    data_t       rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    data_t       sum;
    count_t      received;
    logic        done;

    data_t       shadow [REG_NUM];  // Expected register contents.
    data_t       exp_rdata;
    data_t       exp_sum;
    count_t      exp_count;
    logic        check_idle;
    logic [31:0] lcg_state;
    int          error_count;

    stream_top stream_top_inst (.*);

    initial begin
        s_axi4l = 1'b0;
        forever #4 s_axi4l = ~s_axi4l;
    end

    // ======================================================================
    // Checks
    // ======================================================================
    task automatic report_failure(input string msg);
        error_count++;
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at the first error.");
    endtask

    a_reset_idle: assert property (@(posedge s_axi4l)
        $rose(rst_n) |-> !bvalid && !rvalid && !done)
        else report_failure("bvalid, rvalid or done high after reset");

    a_read_value: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        rvalid && rready |-> rdata == exp_rdata)
        else report_failure("read data differs from the expected register value");

    a_read_held: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else report_failure("read response changed while rready was low");

    a_write_held: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else report_failure("bvalid dropped while bready was low");

    // Address and data are accepted together, and only when both are offered.
    a_write_ready: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        wready == awready && (!awready || (awvalid && wvalid)))
        else report_failure("awready and wready disagree with the write handshake");

    a_write_okay: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        bvalid |-> bresp == 2'b00)
        else report_failure("write response is not OKAY");

    a_read_okay: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        rvalid |-> rresp == 2'b00)
        else report_failure("read response is not OKAY");

    // Both the count and the checksum are final on the edge that raises done.
    a_run_result: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        $rose(done) |-> received == exp_count && sum == exp_sum)
        else report_failure("sum or received count wrong at the end of a run");

    a_cleared: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        check_idle |-> sum == '0 && received == '0 && !done)
        else report_failure("status not cleared after enable was dropped");

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'((next_rand() >> 8) % 32'(hi - lo + 1));
    endfunction

    // Sum of start + k*step for k below n, wrapping at 32 bits.
    function automatic data_t series_sum(input data_t first, input data_t incr, input count_t n);
        data_t acc;
        acc = '0;
        for (int k = 0; k < int'(n); k++) begin
            acc = acc + first + data_t'(k) * incr;
        end
        return acc;
    endfunction

    task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                             input int bdelay);
        @(posedge s_axi4l);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        bready  <= 1'b0;
        @(negedge s_axi4l);
        while (!awready) @(negedge s_axi4l);
        @(posedge s_axi4l);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (bdelay) @(posedge s_axi4l);
        bready <= 1'b1;
        @(negedge s_axi4l);
        while (!bvalid) @(negedge s_axi4l);
        @(posedge s_axi4l);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, input int rdelay);
        @(posedge s_axi4l);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b0;
        @(negedge s_axi4l);
        while (!arready) @(negedge s_axi4l);
        @(posedge s_axi4l);
        arvalid <= 1'b0;
        repeat (rdelay) @(posedge s_axi4l);     // Response must hold meanwhile.
        rready <= 1'b1;
        @(negedge s_axi4l);
        while (!rvalid) @(negedge s_axi4l);
        @(posedge s_axi4l);
        rready <= 1'b0;
    endtask

    task automatic write_reg(input int idx, input data_t data, input strb_t strb,
                             input int bdelay);
        data_t mask;
        for (int b = 0; b < STRB_W; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        shadow[idx] = (shadow[idx] & ~mask) | (data & mask);
        axi_write(addr_t'(idx * 4), data, strb, bdelay);
    endtask

    task automatic read_reg(input int idx, input int rdelay);
        exp_rdata = shadow[idx];
        axi_read(addr_t'(idx * 4), rdelay);
    endtask

    task automatic wait_done();
        @(negedge s_axi4l);
        while (!done) @(negedge s_axi4l);
    endtask

    task automatic check_cleared();
        @(posedge s_axi4l);
        check_idle <= 1'b1;
        repeat (4) @(posedge s_axi4l);
        check_idle <= 1'b0;
    endtask

    task automatic run_stream(input int min_count, input int max_count, input int min_gap,
                              input int max_gap, input bit abort);
        data_t  start;
        data_t  step;
        count_t count;
        gap_t   gap;
        start     = next_rand();
        step      = next_rand();
        count     = count_t'(rand_range(min_count, max_count));
        gap       = gap_t'(rand_range(min_gap, max_gap));
        exp_count = count;
        exp_sum   = series_sum(start, step, count);
        write_reg(REG_START, start, 4'hf, 0);
        write_reg(REG_STEP, step, 4'hf, 0);
        write_reg(REG_LEN, {8'h00, gap, count}, 4'hf, 0);
        write_reg(REG_CTRL, 32'h1, 4'hf, 0);
        if (abort) begin
            repeat (12) @(posedge s_axi4l);     // Buffer is full of words here.
        end else begin
            wait_done();
        end
        write_reg(REG_CTRL, 32'h0, 4'hf, rand_range(0, 3));
        check_cleared();
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        int    idx;
        data_t wr_val;
        int    bdelay;
        rst_n       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        check_idle  = 1'b0;
        exp_rdata   = '0;
        exp_sum     = '0;
        exp_count   = '0;
        lcg_state   = SEED;
        error_count = 0;
        for (int i = 0; i < REG_NUM; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge s_axi4l);
        rst_n <= 1'b1;

        for (int i = 0; i < REG_NUM; i++) begin
            read_reg(i, 0);
        end

        for (int i = 0; i < 8; i++) begin
            idx    = rand_range(REG_START, REG_LEN);
            wr_val = next_rand();
            bdelay = rand_range(0, 3);
            write_reg(idx, wr_val, STRB_LIST[i], bdelay);
            read_reg(idx, rand_range(0, 3));
        end

        run_stream(1, MAX_COUNT, 0, 0, 1'b0);
        run_stream(FIFO_DEPTH + 1, MAX_COUNT, 4, MAX_GAP, 1'b0);
        run_stream(FIFO_DEPTH + 1, MAX_COUNT, 4, MAX_GAP, 1'b0);
        run_stream(20, MAX_COUNT, 3, MAX_GAP, 1'b1);
        run_stream(1, MAX_COUNT, 0, MAX_GAP, 1'b0);
        run_stream(1, MAX_COUNT, 0, MAX_GAP, 1'b0);

        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge s_axi4l);
        $display("Timeout: the test did not finish within %0d clock cycles.", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired.");
    end

endmodule

// File: list.f
verilog/stream_pkg.sv
verilog/axi4l_register.sv
verilog/pattern_producer.sv
verilog/credit_fifo.sv
verilog/checksum_consumer.sv
verilog/stream_top.sv
sim/stream_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the stream testbench with Verilator, runs it and judges the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
FAIL_MSG='*** TEST FAILED ***'

verilator --binary --timing --assert -Wno-fatal \
    --top-module stream_tb --Mdir "$BUILD_DIR" -o stream_sim -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

"./$BUILD_DIR/stream_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported a failure, see $LOG."
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status."
    exit 1
fi

echo "Simulation finished cleanly."
exit 0
